// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

	localparam int NUM_LANES = 16;
	localparam int WORD_BITS = 32;
	localparam int LINE_BITS = NUM_LANES * WORD_BITS;	// 64-byte line
	localparam int OFFSET_BITS = 6;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [NUM_LANES-1:0] lane_mask_t;
	typedef logic [LINE_BITS/8-1:0] byte_mask_t;	// One bit per byte of the line
	typedef logic [3:0] lane_idx_t;
	typedef logic [31:0] addr_t;

endpackage

// ==== hw/lane_store_unit.sv ====
`timescale 1ns/1ps

module lane_store_unit
(
	input dcache_pkg::lane_idx_t lane_id,
	lane_req_if.lane req,
	output dcache_pkg::word_t data,
	output logic [3:0] byte_en
);

	dcache_pkg::word_t line_word;
	dcache_pkg::word_t scalar_be;
	dcache_pkg::word_t line_be;
	logic [3:0] be;

	// Register byte order to memory byte order
	function automatic dcache_pkg::word_t swap_bytes(input dcache_pkg::word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Lane 0 sits in the top word of the line
	assign line_word = req.store_line[{~lane_id, 5'd0} +: 32];
	assign line_be = swap_bytes(line_word);
	assign scalar_be = swap_bytes(req.scalar_word);

	always_comb
	begin
		case (req.kind)
			ma_isa_pkg::BYTE:
			begin
				data = {scalar_be[31:24], 24'd0} >> {req.addr_low, 3'b000};
				be = 4'b1000 >> req.addr_low;
			end

			ma_isa_pkg::HALF:
			begin
				// Low address bit ignored here
				data = {scalar_be[31:16], 16'd0} >> {req.addr_low[1], 4'b0000};
				be = 4'b1100 >> {req.addr_low[1], 1'b0};
			end

			ma_isa_pkg::WORD, ma_isa_pkg::LANE_WORD:
			begin
				data = scalar_be;
				be = 4'b1111;
			end

			ma_isa_pkg::LINE:
			begin
				data = line_be;
				be = 4'b1111;
			end

			default:
			begin
				data = '0;
				be = 4'b0000;
			end
		endcase
	end

	assign byte_en = req.lane_enable[~lane_id] ? be : 4'b0000;

endmodule

// ==== hw/line_request_merge.sv ====
`timescale 1ns/1ps

module line_request_merge
(
	input logic clk,
	input logic arst_n,
	dcache_cmd_if.drain cmd,
	input dcache_pkg::word_t lane_data [dcache_pkg::NUM_LANES],
	input logic [3:0] lane_byte_en [dcache_pkg::NUM_LANES],
	output dcache_pkg::line_t data_to_dcache,
	output dcache_pkg::byte_mask_t dcache_store_mask,
	output dcache_pkg::addr_t dcache_addr,
	output logic dcache_load,
	output logic dcache_store,
	output logic dcache_flush,
	output logic dcache_barrier,
	output logic dcache_req_sync,
	output ma_isa_pkg::strand_t dcache_req_strand
);

	dcache_pkg::line_t line_nxt;
	dcache_pkg::byte_mask_t mask_nxt;
	dcache_pkg::byte_mask_t store_mask_nxt;

	// Lane 0 lands in the most significant word and mask nibble
	always_comb
	begin
		line_nxt = '0;
		mask_nxt = '0;
		for (int i = 0; i < dcache_pkg::NUM_LANES; i++)
		begin
			line_nxt[(dcache_pkg::NUM_LANES - 1 - i) * 32 +: 32] = lane_data[i];
			mask_nxt[(dcache_pkg::NUM_LANES - 1 - i) * 4 +: 4] = lane_byte_en[i];
		end
	end

	// No write enables on anything but a store
	assign store_mask_nxt = cmd.store ? mask_nxt : '0;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dcache_load <= 1'b0;
			dcache_store <= 1'b0;
			dcache_flush <= 1'b0;
			dcache_barrier <= 1'b0;
			dcache_req_sync <= 1'b0;
			dcache_store_mask <= '0;
		end
		else
		begin
			dcache_load <= cmd.load;
			dcache_store <= cmd.store;
			dcache_flush <= cmd.flush;
			dcache_barrier <= cmd.barrier;
			dcache_req_sync <= cmd.sync;
			dcache_store_mask <= store_mask_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		data_to_dcache <= line_nxt;
		dcache_addr <= cmd.line_addr;
		dcache_req_strand <= cmd.strand;
	end

endmodule

// ==== hw/ma_decode.sv ====
`timescale 1ns/1ps

module ma_decode
(
	input logic clk,
	input logic arst_n,
	input ma_isa_pkg::instr_t instruction,
	input ma_isa_pkg::strand_t strand,
	input logic flush_ma,
	input dcache_pkg::line_t store_value,
	input dcache_pkg::line_t result,
	input dcache_pkg::lane_mask_t mask,
	input dcache_pkg::lane_idx_t reg_lane_select,
	input dcache_pkg::addr_t base_addr,
	input dcache_pkg::addr_t strided_offset,
	input logic has_writeback,
	input ma_isa_pkg::reg_idx_t writeback_reg,
	lane_req_if.feeder lanes,
	dcache_cmd_if.feeder cmd,
	output ma_isa_pkg::instr_t ma_instruction,
	output ma_isa_pkg::strand_t ma_strand,
	output dcache_pkg::line_t ma_result,
	output logic ma_has_writeback,
	output ma_isa_pkg::reg_idx_t ma_writeback_reg,
	output logic ma_was_load,
	output dcache_pkg::lane_idx_t ma_cache_lane_select,
	output logic [ma_isa_pkg::NUM_STRANDS-1:0] ma_strand_enable,
	output logic ma_unaligned
);

	logic is_fmt_c;
	logic is_fmt_d;
	logic is_load;
	logic is_cr;
	logic is_block;
	logic is_strided;
	logic is_scgath;
	logic lane_active;
	logic misaligned;
	logic load_nxt;
	ma_isa_pkg::mem_op_t c_op;
	ma_isa_pkg::cache_op_t d_op;
	ma_isa_pkg::cr_num_t cr_num;
	ma_isa_pkg::access_kind_e kind;
	logic [8:0] sel_lsb;
	dcache_pkg::word_t store_lane;
	dcache_pkg::word_t ptr_lane;
	dcache_pkg::addr_t ptr;
	dcache_pkg::lane_idx_t cache_lane;
	dcache_pkg::lane_mask_t lane_hit;
	dcache_pkg::lane_mask_t lane_enable;
	dcache_pkg::word_t cr_rdata;
	dcache_pkg::word_t scratch;
	dcache_pkg::line_t result_nxt;

	assign is_fmt_c = instruction[31:30] == ma_isa_pkg::FMT_C_TAG;
	assign is_fmt_d = instruction[31:28] == ma_isa_pkg::FMT_D_TAG;
	assign is_load = instruction[ma_isa_pkg::LOAD_BIT];
	assign c_op = instruction[ma_isa_pkg::MEM_OP_LSB +: 4];
	assign d_op = instruction[ma_isa_pkg::CACHE_OP_LSB +: 3];
	assign cr_num = instruction[ma_isa_pkg::CR_NUM_LSB +: 5];
	assign is_cr = is_fmt_c && c_op == ma_isa_pkg::MEM_CONTROL_REG;
	assign is_block = c_op inside {ma_isa_pkg::MEM_BLOCK, ma_isa_pkg::MEM_BLOCK_M,
		ma_isa_pkg::MEM_BLOCK_IM};
	assign is_strided = c_op inside {ma_isa_pkg::MEM_STRIDED, ma_isa_pkg::MEM_STRIDED_M,
		ma_isa_pkg::MEM_STRIDED_IM};
	assign is_scgath = c_op inside {ma_isa_pkg::MEM_SCGATH, ma_isa_pkg::MEM_SCGATH_M,
		ma_isa_pkg::MEM_SCGATH_IM};

	always_comb
	begin
		if (is_block)
			kind = ma_isa_pkg::LINE;
		else if (is_strided || is_scgath)
			kind = ma_isa_pkg::LANE_WORD;
		else if (c_op inside {ma_isa_pkg::MEM_B, ma_isa_pkg::MEM_BX})
			kind = ma_isa_pkg::BYTE;
		else if (c_op inside {ma_isa_pkg::MEM_S, ma_isa_pkg::MEM_SX})
			kind = ma_isa_pkg::HALF;
		else
			kind = ma_isa_pkg::WORD;
	end

	// Register lane 0 is the top word
	assign sel_lsb = {~reg_lane_select, 5'd0};
	assign store_lane = store_value[sel_lsb +: 32];
	assign ptr_lane = result[sel_lsb +: 32];

	always_comb
	begin
		if (is_strided)
			ptr = base_addr + strided_offset;
		else if (is_scgath)
			ptr = ptr_lane;
		else
			ptr = result[31:0];	// Scalar and block address
	end

	assign cache_lane = ptr[5:2];
	assign lane_hit = 16'h8000 >> cache_lane;
	assign lane_active = mask[reg_lane_select];

	always_comb
	begin
		if (is_block)
			lane_enable = mask;
		else if (kind == ma_isa_pkg::LANE_WORD)
			lane_enable = lane_active ? lane_hit : '0;
		else
			lane_enable = lane_hit;
	end

	always_comb
	begin
		case (kind)
			ma_isa_pkg::HALF: misaligned = ptr[0];
			ma_isa_pkg::WORD, ma_isa_pkg::LANE_WORD: misaligned = ptr[1:0] != 2'b00;
			ma_isa_pkg::LINE: misaligned = ptr[dcache_pkg::OFFSET_BITS-1:0] != '0;
			default: misaligned = 1'b0;
		endcase
	end

	assign lanes.kind = kind;
	assign lanes.scalar_word = (kind == ma_isa_pkg::LANE_WORD) ? store_lane : store_value[31:0];
	assign lanes.store_line = store_value;
	assign lanes.addr_low = ptr[1:0];
	assign lanes.lane_enable = lane_enable;

	// Masked-off lane of a gather issues no load
	assign load_nxt = !flush_ma && is_fmt_c && is_load && (is_block || (!is_cr && lane_active));

	assign cmd.load = load_nxt;
	assign cmd.store = !flush_ma && is_fmt_c && !is_load && !is_cr;
	assign cmd.flush = !flush_ma && is_fmt_d && d_op == ma_isa_pkg::CACHE_DFLUSH;
	assign cmd.barrier = !flush_ma && is_fmt_d && d_op == ma_isa_pkg::CACHE_BARRIER;
	assign cmd.sync = !flush_ma && is_fmt_c && c_op == ma_isa_pkg::MEM_SYNC;
	assign cmd.line_addr = {ptr[31:dcache_pkg::OFFSET_BITS], {dcache_pkg::OFFSET_BITS{1'b0}}};
	assign cmd.strand = strand;

	// Control register read
	always_comb
	begin
		case (cr_num)
			ma_isa_pkg::CR_STRAND_ID: cr_rdata = {ma_isa_pkg::CORE_ID, strand};
			ma_isa_pkg::CR_SCRATCH: cr_rdata = scratch;
			ma_isa_pkg::CR_STRAND_EN: cr_rdata = {28'd0, ma_strand_enable};
			default: cr_rdata = '0;
		endcase
	end

	assign result_nxt = is_cr ? dcache_pkg::line_t'(cr_rdata) : result;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			scratch <= '0;
			ma_strand_enable <= 4'b0001;	// Only strand 0 runs out of reset
		end
		else if (!flush_ma && is_cr && !is_load)
		begin
			case (cr_num)
				ma_isa_pkg::CR_SCRATCH: scratch <= store_value[31:0];
				ma_isa_pkg::CR_STRAND_EN: ma_strand_enable <= store_value[3:0];
				ma_isa_pkg::CR_HALT: ma_strand_enable <= '0;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ma_instruction <= ma_isa_pkg::NOP_INSTR;
			ma_has_writeback <= 1'b0;
			ma_was_load <= 1'b0;
			ma_unaligned <= 1'b0;
		end
		else
		begin
			ma_instruction <= flush_ma ? ma_isa_pkg::NOP_INSTR : instruction;
			ma_has_writeback <= has_writeback && !flush_ma;
			ma_was_load <= load_nxt;
			ma_unaligned <= misaligned && is_fmt_c && !is_cr && !flush_ma;
		end
	end

	always_ff @(posedge clk)
	begin
		ma_strand <= strand;
		ma_writeback_reg <= writeback_reg;
		ma_result <= result_nxt;
		ma_cache_lane_select <= cache_lane;
	end

endmodule

// ==== hw/ma_ifs.sv ====
`timescale 1ns/1ps

// Store layout request from the decoder to every cache lane
interface lane_req_if;

	ma_isa_pkg::access_kind_e kind;
	dcache_pkg::word_t scalar_word;
	dcache_pkg::line_t store_line;
	logic [1:0] addr_low;
	dcache_pkg::lane_mask_t lane_enable;	// Bit 15 is cache lane 0

	modport feeder
	(
		output kind,
		output scalar_word,
		output store_line,
		output addr_low,
		output lane_enable
	);

	modport lane
	(
		input kind,
		input scalar_word,
		input store_line,
		input addr_low,
		input lane_enable
	);

endinterface

interface dcache_cmd_if;

	logic load;
	logic store;
	logic flush;
	logic barrier;
	logic sync;
	dcache_pkg::addr_t line_addr;
	ma_isa_pkg::strand_t strand;

	modport feeder
	(
		output load,
		output store,
		output flush,
		output barrier,
		output sync,
		output line_addr,
		output strand
	);

	modport drain
	(
		input load,
		input store,
		input flush,
		input barrier,
		input sync,
		input line_addr,
		input strand
	);

endinterface

// ==== hw/ma_isa_pkg.sv ====
package ma_isa_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [3:0] mem_op_t;
	typedef logic [2:0] cache_op_t;
	typedef logic [4:0] cr_num_t;
	typedef logic [1:0] strand_t;
	typedef logic [6:0] reg_idx_t;

	localparam int NUM_STRANDS = 4;

	// Instruction field positions
	localparam logic [1:0] FMT_C_TAG = 2'b10;		// Bits 31:30
	localparam logic [3:0] FMT_D_TAG = 4'b1110;	// Bits 31:28
	localparam int LOAD_BIT = 29;
	localparam int MEM_OP_LSB = 25;	// Format C, 4 bits
	localparam int CACHE_OP_LSB = 25;	// Format D, 3 bits
	localparam int CR_NUM_LSB = 0;

	localparam mem_op_t MEM_B = 4'd0;
	localparam mem_op_t MEM_BX = 4'd1;
	localparam mem_op_t MEM_S = 4'd2;
	localparam mem_op_t MEM_SX = 4'd3;
	localparam mem_op_t MEM_L = 4'd4;
	localparam mem_op_t MEM_SYNC = 4'd5;
	localparam mem_op_t MEM_CONTROL_REG = 4'd6;
	localparam mem_op_t MEM_BLOCK = 4'd7;
	localparam mem_op_t MEM_BLOCK_M = 4'd8;
	localparam mem_op_t MEM_BLOCK_IM = 4'd9;
	localparam mem_op_t MEM_STRIDED = 4'd10;
	localparam mem_op_t MEM_STRIDED_M = 4'd11;
	localparam mem_op_t MEM_STRIDED_IM = 4'd12;
	localparam mem_op_t MEM_SCGATH = 4'd13;
	localparam mem_op_t MEM_SCGATH_M = 4'd14;
	localparam mem_op_t MEM_SCGATH_IM = 4'd15;

	localparam cache_op_t CACHE_DFLUSH = 3'b010;
	localparam cache_op_t CACHE_BARRIER = 3'b100;

	localparam cr_num_t CR_STRAND_ID = 5'd0;
	localparam cr_num_t CR_SCRATCH = 5'd7;
	localparam cr_num_t CR_STRAND_EN = 5'd30;
	localparam cr_num_t CR_HALT = 5'd31;

	localparam instr_t NOP_INSTR = 32'h0000_0000;
	localparam logic [29:0] CORE_ID = 30'd0;

	// Store layout class seen by the lanes
	typedef enum logic [2:0] {BYTE, HALF, WORD, LANE_WORD, LINE} access_kind_e;

endpackage

// ==== hw/memory_access_top.sv ====
`timescale 1ns/1ps

module memory_access_top
(
	input logic clk,
	input logic arst_n,
	input logic flush_ma,
	input ma_isa_pkg::instr_t ex_instruction,
	input ma_isa_pkg::strand_t ex_strand,
	input dcache_pkg::line_t ex_store_value,
	input dcache_pkg::line_t ex_result,
	input dcache_pkg::lane_mask_t ex_mask,
	input dcache_pkg::lane_idx_t ex_reg_lane_select,
	input dcache_pkg::addr_t ex_base_addr,
	input dcache_pkg::addr_t ex_strided_offset,
	input logic ex_has_writeback,
	input ma_isa_pkg::reg_idx_t ex_writeback_reg,
	output dcache_pkg::line_t data_to_dcache,
	output dcache_pkg::byte_mask_t dcache_store_mask,
	output dcache_pkg::addr_t dcache_addr,
	output logic dcache_load,
	output logic dcache_store,
	output logic dcache_flush,
	output logic dcache_barrier,
	output logic dcache_req_sync,
	output ma_isa_pkg::strand_t dcache_req_strand,
	output ma_isa_pkg::instr_t ma_instruction,
	output ma_isa_pkg::strand_t ma_strand,
	output dcache_pkg::line_t ma_result,
	output logic ma_has_writeback,
	output ma_isa_pkg::reg_idx_t ma_writeback_reg,
	output logic ma_was_load,
	output dcache_pkg::lane_idx_t ma_cache_lane_select,
	output logic [ma_isa_pkg::NUM_STRANDS-1:0] ma_strand_enable,
	output logic ma_unaligned
);

	lane_req_if lane_req();
	dcache_cmd_if dcache_cmd();

	dcache_pkg::word_t lane_data [dcache_pkg::NUM_LANES];
	logic [3:0] lane_byte_en [dcache_pkg::NUM_LANES];

	ma_decode u_decode
	(
		.clk(clk),
		.arst_n(arst_n),
		.instruction(ex_instruction),
		.strand(ex_strand),
		.flush_ma(flush_ma),
		.store_value(ex_store_value),
		.result(ex_result),
		.mask(ex_mask),
		.reg_lane_select(ex_reg_lane_select),
		.base_addr(ex_base_addr),
		.strided_offset(ex_strided_offset),
		.has_writeback(ex_has_writeback),
		.writeback_reg(ex_writeback_reg),
		.lanes(lane_req),
		.cmd(dcache_cmd),
		.ma_instruction(ma_instruction),
		.ma_strand(ma_strand),
		.ma_result(ma_result),
		.ma_has_writeback(ma_has_writeback),
		.ma_writeback_reg(ma_writeback_reg),
		.ma_was_load(ma_was_load),
		.ma_cache_lane_select(ma_cache_lane_select),
		.ma_strand_enable(ma_strand_enable),
		.ma_unaligned(ma_unaligned)
	);

	for (genvar g = 0; g < dcache_pkg::NUM_LANES; g++)
	begin : g_lane
		lane_store_unit u_lane
		(
			.lane_id(dcache_pkg::lane_idx_t'(g)),
			.req(lane_req),
			.data(lane_data[g]),
			.byte_en(lane_byte_en[g])
		);
	end

	line_request_merge u_merge
	(
		.clk(clk),
		.arst_n(arst_n),
		.cmd(dcache_cmd),
		.lane_data(lane_data),
		.lane_byte_en(lane_byte_en),
		.data_to_dcache(data_to_dcache),
		.dcache_store_mask(dcache_store_mask),
		.dcache_addr(dcache_addr),
		.dcache_load(dcache_load),
		.dcache_store(dcache_store),
		.dcache_flush(dcache_flush),
		.dcache_barrier(dcache_barrier),
		.dcache_req_sync(dcache_req_sync),
		.dcache_req_strand(dcache_req_strand)
	);

endmodule

// ==== sim.f ====
+incdir+tb
hw/ma_isa_pkg.sv
hw/dcache_pkg.sv
hw/ma_ifs.sv
hw/lane_store_unit.sv
hw/line_request_merge.sv
hw/ma_decode.sv
hw/memory_access_top.sv
tb/tb_memory_access.sv

// ==== tb/ma_stimulus.txt ====
# name flush instr strand sv sv_step res res_step mask sel base stride wb, then expected:
# data data_step store_mask addr strobes(ld st fl br sy) instr wb result strand_en unaligned
sb_off0 0 80000000 0 1234ABCD 0 00001000 0 FFFF 0 0 0 0 CD000000 0 8000000000000000 00001000 08 80000000 0 00001000 1 0
sb_off1 0 80000000 0 1234ABCD 0 00001005 0 FFFF 0 0 0 0 00CD0000 0 0400000000000000 00001000 08 80000000 0 00001005 1 0
sb_off2 0 80000000 0 1234ABCD 0 0000100A 0 FFFF 0 0 0 0 0000CD00 0 0020000000000000 00001000 08 80000000 0 0000100A 1 0
sb_off3 0 80000000 0 1234ABCD 0 0000103F 0 FFFF 0 0 0 0 000000CD 0 0000000000000001 00001000 08 80000000 0 0000103F 1 0
sh_off0 0 84000000 0 1234ABCD 0 00002004 0 FFFF 0 0 0 0 CDAB0000 0 0C00000000000000 00002000 08 84000000 0 00002004 1 0
sh_off2 0 84000000 0 1234ABCD 0 00002032 0 FFFF 0 0 0 0 0000CDAB 0 0000000000003000 00002000 08 84000000 0 00002032 1 0
sw_aligned 0 88000000 0 1234ABCD 0 00003028 0 FFFF 0 0 0 0 CDAB3412 0 0000000000F00000 00003000 08 88000000 0 00003028 1 0
sh_unaligned 0 84000000 0 1234ABCD 0 00002001 0 FFFF 0 0 0 0 CDAB0000 0 C000000000000000 00002000 08 84000000 0 00002001 1 1
sw_unaligned 0 88000000 0 1234ABCD 0 00003006 0 FFFF 0 0 0 0 CDAB3412 0 0F00000000000000 00003000 08 88000000 0 00003006 1 1
lw_aligned 0 A8000000 0 00000000 0 00004010 0 FFFF 0 0 0 1 00000000 0 0000000000000000 00004000 10 A8000000 1 00004010 1 0
blk_store 0 8E000000 0 11223300 1 00005000 0 A5F0 0 0 0 0 00332211 01000000 F0F00F0FFFFF0000 00005000 08 8E000000 0 00005000 1 0
blk_unaligned 0 8E000000 0 00000000 0 00005020 0 FFFF 0 0 0 0 00000000 0 FFFFFFFFFFFFFFFF 00005000 08 8E000000 0 00005020 1 1
blk_load 0 AE000000 0 00000000 0 00006000 0 0000 0 0 0 1 00000000 0 0000000000000000 00006000 10 AE000000 1 00006000 1 0
strided_on 0 94000000 0 A0B0C000 10 00000000 0 FFFF 3 00007000 00000024 0 30C0B0A0 0 000000000F000000 00007000 08 94000000 0 00000000 1 0
strided_off 0 94000000 0 A0B0C000 10 00000000 0 FFF7 3 00007000 00000024 0 30C0B0A0 0 0000000000000000 00007000 08 94000000 0 00000000 1 0
scatter_on 0 9A000000 0 A0B0C000 10 00008000 4 FFFF 5 0 0 0 50C0B0A0 0 00000F0000000000 00008000 08 9A000000 0 0000803C 1 0
gather_masked 0 BC000000 0 00000000 0 00008000 4 FFDF 5 0 0 1 00000000 0 0000000000000000 00008000 00 BC000000 1 0000803C 1 0
gather_on 0 BC000000 0 00000000 0 00008000 4 FFFF 5 0 0 1 00000000 0 0000000000000000 00008000 10 BC000000 1 0000803C 1 0
dflush 0 E4000000 0 00000000 0 00009040 0 FFFF 0 0 0 0 00000000 0 0000000000000000 00009040 04 E4000000 0 00009040 1 0
barrier 0 E8000000 0 00000000 0 00000000 0 FFFF 0 0 0 0 00000000 0 0000000000000000 00000000 02 E8000000 0 00000000 1 0
kill_store 1 88000000 0 1234ABCD 0 00003028 0 FFFF 0 0 0 1 CDAB3412 0 0000000000000000 00003000 00 00000000 0 00003028 1 0
kill_cr_write 1 8C000007 0 DEADBEEF 0 00000000 0 FFFF 0 0 0 0 EFBEADDE 0 0000000000000000 00000000 00 00000000 0 00000000 1 0
scratch_rd0 0 AC000007 0 00000000 0 00000000 0 FFFF 0 0 0 1 00000000 0 0000000000000000 00000000 00 AC000007 1 00000000 1 0
scratch_wr 0 8C000007 0 5A5AC3C3 0 00000000 0 FFFF 0 0 0 0 C3C35A5A 0 0000000000000000 00000000 00 8C000007 0 00000000 1 0
scratch_rd 0 AC000007 0 00000000 0 00000000 0 FFFF 0 0 0 1 00000000 0 0000000000000000 00000000 00 AC000007 1 5A5AC3C3 1 0
strand_id 0 AC000000 2 00000000 0 00000000 0 FFFF 0 0 0 1 00000000 0 0000000000000000 00000000 00 AC000000 1 00000002 1 0
strand_en_wr 0 8C00001E 0 0000000B 0 00000000 0 FFFF 0 0 0 0 0B000000 0 0000000000000000 00000000 00 8C00001E 0 00000001 B 0
strand_en_rd 0 AC00001E 0 00000000 0 00000000 0 FFFF 0 0 0 1 00000000 0 0000000000000000 00000000 00 AC00001E 1 0000000B B 0
halt 0 8C00001F 0 00000000 0 00000000 0 FFFF 0 0 0 0 00000000 0 0000000000000000 00000000 00 8C00001F 0 00000000 0 0
cr_unknown 0 AC000003 0 00000000 0 00000000 0 FFFF 0 0 0 1 00000000 0 0000000000000000 00000000 00 AC000003 1 00000000 0 0
nop 0 00000000 0 00000000 0 00000000 0 FFFF 0 0 0 0 00000000 0 0000000000000000 00000000 00 00000000 0 00000000 0 0

// ==== tb/ma_check_tasks.svh ====
`ifndef MA_CHECK_TASKS_SVH
`define MA_CHECK_TASKS_SVH

int value_errors = 0;
int other_errors = 0;

task automatic check_line(input string test, input string field,
	input dcache_pkg::line_t expected, input dcache_pkg::line_t actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
	end
endtask

task automatic check_mask(input string test, input string field,
	input dcache_pkg::byte_mask_t expected, input dcache_pkg::byte_mask_t actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
	end
endtask

task automatic check_addr(input string test, input string field,
	input dcache_pkg::addr_t expected, input dcache_pkg::addr_t actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
	end
endtask

task automatic check_word(input string test, input string field,
	input dcache_pkg::word_t expected, input dcache_pkg::word_t actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
	end
endtask

task automatic check_lane(input string test, input string field,
	input dcache_pkg::lane_idx_t expected, input dcache_pkg::lane_idx_t actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
	end
endtask

task automatic check_strand(input string test, input string field,
	input ma_isa_pkg::strand_t expected, input ma_isa_pkg::strand_t actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
	end
endtask

task automatic check_reg(input string test, input string field,
	input ma_isa_pkg::reg_idx_t expected, input ma_isa_pkg::reg_idx_t actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
	end
endtask

task automatic check_bit(input string test, input string field,
	input logic expected, input logic actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("Fail %s %s: expected %b, actual %b", test, field, expected, actual);
	end
endtask

// Failures that carry no expected value
task automatic report_problem(input string what);
	other_errors++;
	$display("Error: %s", what);
endtask

task automatic print_error_counts();
	$display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
endtask

`endif

// ==== tb/tb_memory_access.sv ====
`timescale 1ns/1ps

module tb_memory_access;

	localparam int MAX_VECTORS = 64;
	localparam int NUM_FIELDS = 22;

	// Column order of a stimulus line after the test name
	typedef enum int
	{
		F_FLUSH, F_INSTR, F_STRAND, F_SV, F_SV_STEP, F_RES, F_RES_STEP, F_MASK, F_SEL,
		F_BASE, F_STRIDE, F_WB, F_E_DATA, F_E_STEP, F_E_MASK, F_E_ADDR, F_E_STRB,
		F_E_INSTR, F_E_WB, F_E_RES, F_E_SEN, F_E_UNAL
	} field_e;

	logic clk;
	logic arst_n;
	logic flush_ma;
	ma_isa_pkg::instr_t ex_instruction;
	ma_isa_pkg::strand_t ex_strand;
	dcache_pkg::line_t ex_store_value;
	dcache_pkg::line_t ex_result;
	dcache_pkg::lane_mask_t ex_mask;
	dcache_pkg::lane_idx_t ex_reg_lane_select;
	dcache_pkg::addr_t ex_base_addr;
	dcache_pkg::addr_t ex_strided_offset;
	logic ex_has_writeback;
	ma_isa_pkg::reg_idx_t ex_writeback_reg;

	dcache_pkg::line_t data_to_dcache;
	dcache_pkg::byte_mask_t dcache_store_mask;
	dcache_pkg::addr_t dcache_addr;
	logic dcache_load;
	logic dcache_store;
	logic dcache_flush;
	logic dcache_barrier;
	logic dcache_req_sync;
	ma_isa_pkg::strand_t dcache_req_strand;
	ma_isa_pkg::instr_t ma_instruction;
	ma_isa_pkg::strand_t ma_strand;
	dcache_pkg::line_t ma_result;
	logic ma_has_writeback;
	ma_isa_pkg::reg_idx_t ma_writeback_reg;
	logic ma_was_load;
	dcache_pkg::lane_idx_t ma_cache_lane_select;
	logic [ma_isa_pkg::NUM_STRANDS-1:0] ma_strand_enable;
	logic ma_unaligned;

	string vec_name [MAX_VECTORS];
	logic [63:0] vec [MAX_VECTORS][NUM_FIELDS];
	ma_isa_pkg::reg_idx_t wb_reg_sent [MAX_VECTORS];
	int num_vectors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;	// Zero until the vectors are loaded

	`include "ma_check_tasks.svh"

	memory_access_top UUT
	(
		.clk(clk),
		.arst_n(arst_n),
		.flush_ma(flush_ma),
		.ex_instruction(ex_instruction),
		.ex_strand(ex_strand),
		.ex_store_value(ex_store_value),
		.ex_result(ex_result),
		.ex_mask(ex_mask),
		.ex_reg_lane_select(ex_reg_lane_select),
		.ex_base_addr(ex_base_addr),
		.ex_strided_offset(ex_strided_offset),
		.ex_has_writeback(ex_has_writeback),
		.ex_writeback_reg(ex_writeback_reg),
		.data_to_dcache(data_to_dcache),
		.dcache_store_mask(dcache_store_mask),
		.dcache_addr(dcache_addr),
		.dcache_load(dcache_load),
		.dcache_store(dcache_store),
		.dcache_flush(dcache_flush),
		.dcache_barrier(dcache_barrier),
		.dcache_req_sync(dcache_req_sync),
		.dcache_req_strand(dcache_req_strand),
		.ma_instruction(ma_instruction),
		.ma_strand(ma_strand),
		.ma_result(ma_result),
		.ma_has_writeback(ma_has_writeback),
		.ma_writeback_reg(ma_writeback_reg),
		.ma_was_load(ma_was_load),
		.ma_cache_lane_select(ma_cache_lane_select),
		.ma_strand_enable(ma_strand_enable),
		.ma_unaligned(ma_unaligned)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			report_problem($sformatf("run timed out after %0d cycles", cycle_count));
			print_error_counts();
			$display("Result: FAILED");
			$finish;
		end
	end

	// Word i of the line is base + i * step, word 0 on top
	function automatic dcache_pkg::line_t make_line(input dcache_pkg::word_t base,
		input dcache_pkg::word_t step);
		dcache_pkg::line_t l;
		l = '0;
		for (int i = 0; i < dcache_pkg::NUM_LANES; i++)
			l[(dcache_pkg::NUM_LANES - 1 - i) * 32 +: 32] = base + step * i;
		return l;
	endfunction

	// Cache lane of the access pointer
	function automatic dcache_pkg::lane_idx_t expected_lane(input int i);
		ma_isa_pkg::instr_t instr;
		ma_isa_pkg::mem_op_t op;
		dcache_pkg::addr_t p;
		instr = vec[i][F_INSTR][31:0];
		op = instr[28:25];
		if (instr[31:30] == 2'b10 && op inside {ma_isa_pkg::MEM_STRIDED,
			ma_isa_pkg::MEM_STRIDED_M, ma_isa_pkg::MEM_STRIDED_IM})
			p = vec[i][F_BASE][31:0] + vec[i][F_STRIDE][31:0];
		else if (instr[31:30] == 2'b10 && op inside {ma_isa_pkg::MEM_SCGATH,
			ma_isa_pkg::MEM_SCGATH_M, ma_isa_pkg::MEM_SCGATH_IM})
			p = vec[i][F_RES][31:0] + vec[i][F_RES_STEP][31:0] * vec[i][F_SEL][3:0];
		else
			p = vec[i][F_RES][31:0] + vec[i][F_RES_STEP][31:0] * (dcache_pkg::NUM_LANES - 1);
		return p[5:2];
	endfunction

	task automatic load_vectors();
		int fd;
		int count;
		string line;
		string name;
		logic [63:0] f [NUM_FIELDS];
		fd = $fopen("tb/ma_stimulus.txt", "r");
		if (fd == 0)
		begin
			report_problem("could not open tb/ma_stimulus.txt");
			return;
		end
		while ($fgets(line, fd) > 0)
		begin
			if (line.len() > 0 && line[0] == "#")
				continue;	// Column notes
			count = $sscanf(line,
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
				f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21]);
			if (count == NUM_FIELDS + 1 && num_vectors < MAX_VECTORS)
			begin
				vec_name[num_vectors] = name;
				for (int k = 0; k < NUM_FIELDS; k++)
					vec[num_vectors][k] = f[k];
				num_vectors++;
			end
			else if (count > 0)
				report_problem($sformatf("stimulus line not usable: %s", line));
		end
		$fclose(fd);
		if (num_vectors == 0)
			report_problem("no vectors found in the stimulus file");
	endtask

	task automatic apply_vector(input int i);
		ma_isa_pkg::reg_idx_t wb_reg;
		wb_reg = ma_isa_pkg::reg_idx_t'($urandom);	// Random fill
		wb_reg_sent[i] = wb_reg;
		flush_ma <= vec[i][F_FLUSH][0];
		ex_instruction <= vec[i][F_INSTR][31:0];
		ex_strand <= vec[i][F_STRAND][1:0];
		ex_store_value <= make_line(vec[i][F_SV][31:0], vec[i][F_SV_STEP][31:0]);
		ex_result <= make_line(vec[i][F_RES][31:0], vec[i][F_RES_STEP][31:0]);
		ex_mask <= vec[i][F_MASK][15:0];
		ex_reg_lane_select <= vec[i][F_SEL][3:0];
		ex_base_addr <= vec[i][F_BASE][31:0];
		ex_strided_offset <= vec[i][F_STRIDE][31:0];
		ex_has_writeback <= vec[i][F_WB][0];
		ex_writeback_reg <= wb_reg;
	endtask

	task automatic check_vector(input int i);
		string n;
		logic [4:0] strb;
		ma_isa_pkg::instr_t instr;
		dcache_pkg::line_t res_line;
		n = vec_name[i];
		strb = vec[i][F_E_STRB][4:0];	// load, store, flush, barrier, sync
		instr = vec[i][F_INSTR][31:0];
		res_line = make_line(vec[i][F_RES][31:0], vec[i][F_RES_STEP][31:0]);
		// Control register reads replace the whole result
		if (instr[31:30] == 2'b10 && instr[28:25] == ma_isa_pkg::MEM_CONTROL_REG)
			res_line = '0;
		res_line[31:0] = vec[i][F_E_RES][31:0];
		check_line(n, "data", make_line(vec[i][F_E_DATA][31:0], vec[i][F_E_STEP][31:0]),
			data_to_dcache);
		check_mask(n, "store_mask", vec[i][F_E_MASK], dcache_store_mask);
		check_addr(n, "addr", vec[i][F_E_ADDR][31:0], dcache_addr);
		check_bit(n, "load", strb[4], dcache_load);
		check_bit(n, "store", strb[3], dcache_store);
		check_bit(n, "flush", strb[2], dcache_flush);
		check_bit(n, "barrier", strb[1], dcache_barrier);
		check_bit(n, "sync", strb[0], dcache_req_sync);
		check_strand(n, "req_strand", vec[i][F_STRAND][1:0], dcache_req_strand);
		check_word(n, "instruction", vec[i][F_E_INSTR][31:0], ma_instruction);
		check_strand(n, "strand", vec[i][F_STRAND][1:0], ma_strand);
		check_bit(n, "has_writeback", vec[i][F_E_WB][0], ma_has_writeback);
		check_reg(n, "writeback_reg", wb_reg_sent[i], ma_writeback_reg);
		check_bit(n, "was_load", strb[4], ma_was_load);
		check_lane(n, "cache_lane", expected_lane(i), ma_cache_lane_select);
		check_line(n, "result", res_line, ma_result);
		check_word(n, "strand_enable", vec[i][F_E_SEN][31:0], {28'd0, ma_strand_enable});
		check_bit(n, "unaligned", vec[i][F_E_UNAL][0], ma_unaligned);
	endtask

	task automatic check_reset_state();
		check_bit("reset", "load", 1'b0, dcache_load);
		check_bit("reset", "store", 1'b0, dcache_store);
		check_bit("reset", "flush", 1'b0, dcache_flush);
		check_bit("reset", "barrier", 1'b0, dcache_barrier);
		check_bit("reset", "sync", 1'b0, dcache_req_sync);
		check_bit("reset", "has_writeback", 1'b0, ma_has_writeback);
		check_bit("reset", "unaligned", 1'b0, ma_unaligned);
		check_word("reset", "instruction", 32'h0000_0000, ma_instruction);
		check_word("reset", "strand_enable", 32'h0000_0001, {28'd0, ma_strand_enable});
	endtask

	initial
	begin
		void'($urandom(32'h20c6766b));
		clk = 1'b0;
		arst_n = 1'b0;
		flush_ma = 1'b0;
		ex_instruction = '0;
		ex_strand = '0;
		ex_store_value = '0;
		ex_result = '0;
		ex_mask = '0;
		ex_reg_lane_select = '0;
		ex_base_addr = '0;
		ex_strided_offset = '0;
		ex_has_writeback = 1'b0;
		ex_writeback_reg = ma_isa_pkg::reg_idx_t'($urandom);

		load_vectors();
		cycle_limit = 8 + 4 * num_vectors + 50;

		repeat (7) @(posedge clk);
		@(negedge clk);
		check_reset_state();
		@(posedge clk);
		arst_n <= 1'b1;

		// One cycle latency, results sampled on the falling edge
		for (int i = 0; i < num_vectors; i++)
		begin
			@(posedge clk);
			apply_vector(i);
			@(posedge clk);
			@(negedge clk);
			check_vector(i);
		end

		print_error_counts();
		if (value_errors + other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
